// File: pll_rst_pkg.sv
// Shared constants and state types; cycle counts are fixed, no free-clock frequency scaling
package pll_rst_pkg;

    //////////////////////////////////////////////////
    // Channel count and timing
    //////////////////////////////////////////////////

    // Number of PLL channels, at most 8 (CTRL/STATUS bit fields)
    localparam int PLL_NUM = 2;
    // Ready and soft-reset synchronizer depth
    localparam int SYNC_STAGES = 2;

    // Stable ready cycles before lock is declared
    localparam int LOCK_DEB_CYCLES = 64;
    localparam int DEB_W = $clog2(LOCK_DEB_CYCLES);

    // Wait-for-lock budget before a watchdog restart
    localparam int WD_TIMEOUT_CYCLES = 1024;
    localparam int WD_W = $clog2(WD_TIMEOUT_CYCLES);

    // Phase lengths of the reset sequence
    localparam int PWRDN_CYCLES = 32;
    localparam int RST_CYCLES = 32;
    // Hold counter sized for the longer phase
    localparam int HOLD_W = $clog2((PWRDN_CYCLES > RST_CYCLES) ? PWRDN_CYCLES : RST_CYCLES);

    //////////////////////////////////////////////////
    // Register map, byte offsets
    //////////////////////////////////////////////////
    localparam logic [31:0] REG_CTRL   = 32'h0;
    localparam logic [31:0] REG_STATUS = 32'h4;
    localparam logic [31:0] REG_EVENT  = 32'h8;

    //////////////////////////////////////////////////
    // State encodings
    //////////////////////////////////////////////////
    typedef enum logic [1:0] {
        SEQ_PWRDN,
        SEQ_RST,
        SEQ_WAIT_LOCK,
        SEQ_DONE
    } seq_state_e;

    typedef enum logic {WR_IDLE, WR_RESP} axi_wr_state_e;
    typedef enum logic {RD_IDLE, RD_RESP} axi_rd_state_e;

endpackage

// File: pll_rst_seq.sv
// PLL reset sequencer; i_restart held high keeps the PLL in power-down, phase lengths from package
`timescale 1ns/1ps
module pll_rst_seq (
    input  logic i_clk,
    input  logic i_arst_n,
    input  logic i_restart,
    input  logic i_lock,
    output logic o_waiting,
    output logic o_pll_powerdown,
    output logic o_pll_rst,
    output logic o_done
);

    pll_rst_pkg::seq_state_e        state;
    logic [pll_rst_pkg::HOLD_W-1:0] hold_cnt;
    logic                           pwrdn_end;
    logic                           rst_end;

    assign pwrdn_end = (hold_cnt == pll_rst_pkg::HOLD_W'(pll_rst_pkg::PWRDN_CYCLES - 1));
    assign rst_end   = (hold_cnt == pll_rst_pkg::HOLD_W'(pll_rst_pkg::RST_CYCLES - 1));

    //////////////////////////////////////////////////
    // State machine
    //////////////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state    <= pll_rst_pkg::SEQ_PWRDN;
            hold_cnt <= '0;
        end else if (i_restart) begin
            // Any restart source begins again from power-down
            state    <= pll_rst_pkg::SEQ_PWRDN;
            hold_cnt <= '0;
        end else begin
            case (state)
                pll_rst_pkg::SEQ_PWRDN: begin
                    hold_cnt <= pwrdn_end ? '0 : hold_cnt + 1'b1;
                    if (pwrdn_end) begin
                        state <= pll_rst_pkg::SEQ_RST;
                    end
                end
                pll_rst_pkg::SEQ_RST: begin
                    hold_cnt <= rst_end ? '0 : hold_cnt + 1'b1;
                    if (rst_end) begin
                        state <= pll_rst_pkg::SEQ_WAIT_LOCK;
                    end
                end
                pll_rst_pkg::SEQ_WAIT_LOCK: begin
                    // Timeout is the watchdog's job, not ours
                    if (i_lock) begin
                        state <= pll_rst_pkg::SEQ_DONE;
                    end
                end
                default: begin
                    // Lock lost, redo the reset phase only
                    if (!i_lock) begin
                        state    <= pll_rst_pkg::SEQ_RST;
                        hold_cnt <= '0;
                    end
                end
            endcase
        end
    end

    // Pin levels decoded from state
    assign o_pll_powerdown = (state == pll_rst_pkg::SEQ_PWRDN);
    assign o_pll_rst       = (state == pll_rst_pkg::SEQ_PWRDN) || (state == pll_rst_pkg::SEQ_RST);
    assign o_waiting       = (state == pll_rst_pkg::SEQ_WAIT_LOCK);
    assign o_done          = (state == pll_rst_pkg::SEQ_DONE);

endmodule

// File: pll_rst_chan.sv
// One PLL channel; i_pll_ready is asynchronous, i_soft_rst and i_wd_clr come from i_clk domain
`timescale 1ns/1ps
module pll_rst_chan (
    input  logic       i_clk,
    input  logic       i_arst_n,
    input  logic       i_soft_rst,
    input  logic       i_wd_clr,
    input  logic       i_pll_ready,
    output logic       o_pll_powerdown,
    output logic       o_pll_rst,
    output logic       o_done,
    output logic       o_lock,
    output logic [1:0] o_wd_cnt
);

    // Stage array, bit 1 soft reset, bit 0 ready
    logic [1:0]                    sync_q [pll_rst_pkg::SYNC_STAGES];
    logic                          soft_rst_s;
    logic                          ready_s;
    logic [pll_rst_pkg::DEB_W-1:0] deb_cnt;
    logic [pll_rst_pkg::WD_W-1:0]  wd_timer;
    logic                          wd_timeout;
    logic                          waiting;
    logic                          restart;

    //////////////////////////////////////////////////
    // Synchronizers
    //////////////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < pll_rst_pkg::SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= {i_soft_rst, i_pll_ready};
            for (int i = 1; i < pll_rst_pkg::SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign soft_rst_s = sync_q[pll_rst_pkg::SYNC_STAGES-1][1];
    assign ready_s    = sync_q[pll_rst_pkg::SYNC_STAGES-1][0];

    //////////////////////////////////////////////////
    // Lock debounce
    //////////////////////////////////////////////////

    // Slow rise, immediate fall on a ready drop
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            deb_cnt <= '0;
            o_lock  <= 1'b0;
        end else if (!ready_s) begin
            deb_cnt <= '0;
            o_lock  <= 1'b0;
        end else if (!o_lock) begin
            if (deb_cnt == pll_rst_pkg::DEB_W'(pll_rst_pkg::LOCK_DEB_CYCLES - 1)) begin
                o_lock <= 1'b1;
            end else begin
                deb_cnt <= deb_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Lock watchdog
    //////////////////////////////////////////////////

    // Runs only while the sequencer waits for lock
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wd_timer <= '0;
        end else if (!waiting || wd_timeout) begin
            wd_timer <= '0;
        end else begin
            wd_timer <= wd_timer + 1'b1;
        end
    end

    assign wd_timeout = waiting &&
        (wd_timer == pll_rst_pkg::WD_W'(pll_rst_pkg::WD_TIMEOUT_CYCLES - 1));

    // Restart count saturates at 3; survives restarts, clear wins over a timeout
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_wd_cnt <= 2'd0;
        end else if (i_wd_clr) begin
            o_wd_cnt <= 2'd0;
        end else if (wd_timeout && o_wd_cnt != 2'd3) begin
            o_wd_cnt <= o_wd_cnt + 2'd1;
        end
    end

    // Global reset reaches the sequencer through i_arst_n
    assign restart = soft_rst_s | wd_timeout;

    pll_rst_seq u_seq (
        .i_clk           (i_clk),
        .i_arst_n        (i_arst_n),
        .i_restart       (restart),
        .i_lock          (o_lock),
        .o_waiting       (waiting),
        .o_pll_powerdown (o_pll_powerdown),
        .o_pll_rst       (o_pll_rst),
        .o_done          (o_done)
    );

endmodule

// File: pll_rst_csr.sv
// AXI4-Lite slave, one transaction per channel, full-word writes only (no strobes), OKAY always
`timescale 1ns/1ps
module pll_rst_csr (
    input  logic                              i_clk,
    input  logic                              i_arst_n,
    // AXI4-Lite write address and data
    input  logic [31:0]                       i_s_axi_awaddr,
    input  logic                              i_s_axi_awvalid,
    output logic                              o_s_axi_awready,
    input  logic [31:0]                       i_s_axi_wdata,
    input  logic                              i_s_axi_wvalid,
    output logic                              o_s_axi_wready,
    // Write response
    output logic [1:0]                        o_s_axi_bresp,
    output logic                              o_s_axi_bvalid,
    input  logic                              i_s_axi_bready,
    // Read address and data
    input  logic [31:0]                       i_s_axi_araddr,
    input  logic                              i_s_axi_arvalid,
    output logic                              o_s_axi_arready,
    output logic [31:0]                       o_s_axi_rdata,
    output logic [1:0]                        o_s_axi_rresp,
    output logic                              o_s_axi_rvalid,
    input  logic                              i_s_axi_rready,
    // From the status collector
    input  logic [31:0]                       i_status,
    input  logic [31:0]                       i_event,
    // To channels and collector
    output logic [pll_rst_pkg::PLL_NUM-1:0]   o_soft_rst,
    output logic [pll_rst_pkg::PLL_NUM-1:0]   o_wd_clr,
    output logic [pll_rst_pkg::PLL_NUM-1:0]   o_evt_clr
);

    pll_rst_pkg::axi_wr_state_e wr_state;
    pll_rst_pkg::axi_rd_state_e rd_state;
    logic                       wr_fire;
    logic                       rd_fire;
    logic [31:0]                rd_mux;

    //////////////////////////////////////////////////
    // Write channel
    //////////////////////////////////////////////////

    // Address and data accepted together, only with no response pending
    assign wr_fire         = (wr_state == pll_rst_pkg::WR_IDLE) &&
                             i_s_axi_awvalid && i_s_axi_wvalid;
    assign o_s_axi_awready = wr_fire;
    assign o_s_axi_wready  = wr_fire;
    assign o_s_axi_bvalid  = (wr_state == pll_rst_pkg::WR_RESP);
    assign o_s_axi_bresp   = 2'b00;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_state <= pll_rst_pkg::WR_IDLE;
        end else if (wr_fire) begin
            wr_state <= pll_rst_pkg::WR_RESP;
        end else if (o_s_axi_bvalid && i_s_axi_bready) begin
            wr_state <= pll_rst_pkg::WR_IDLE;
        end
    end

    // Control bits and one-cycle clear pulses
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_soft_rst <= '0;
            o_wd_clr   <= '0;
            o_evt_clr  <= '0;
        end else begin
            // Pulses last a single cycle
            o_wd_clr  <= '0;
            o_evt_clr <= '0;
            if (wr_fire && i_s_axi_awaddr == pll_rst_pkg::REG_CTRL) begin
                o_soft_rst <= i_s_axi_wdata[pll_rst_pkg::PLL_NUM-1:0];
                // Upper byte is write-only, never stored
                o_wd_clr   <= i_s_axi_wdata[8 +: pll_rst_pkg::PLL_NUM];
            end
            if (wr_fire && i_s_axi_awaddr == pll_rst_pkg::REG_EVENT) begin
                // Write 1 to clear
                o_evt_clr <= i_s_axi_wdata[pll_rst_pkg::PLL_NUM-1:0];
            end
        end
    end

    //////////////////////////////////////////////////
    // Read channel
    //////////////////////////////////////////////////
    assign rd_fire         = (rd_state == pll_rst_pkg::RD_IDLE) && i_s_axi_arvalid;
    assign o_s_axi_arready = rd_fire;
    assign o_s_axi_rvalid  = (rd_state == pll_rst_pkg::RD_RESP);
    assign o_s_axi_rresp   = 2'b00;

    // Readback select, unknown offsets give zero
    always_comb begin
        rd_mux = '0;
        case (i_s_axi_araddr)
            pll_rst_pkg::REG_CTRL:   rd_mux[pll_rst_pkg::PLL_NUM-1:0] = o_soft_rst;
            pll_rst_pkg::REG_STATUS: rd_mux = i_status;
            pll_rst_pkg::REG_EVENT:  rd_mux = i_event;
            default:                 rd_mux = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rd_state <= pll_rst_pkg::RD_IDLE;
        end else if (rd_fire) begin
            rd_state <= pll_rst_pkg::RD_RESP;
        end else if (o_s_axi_rvalid && i_s_axi_rready) begin
            rd_state <= pll_rst_pkg::RD_IDLE;
        end
    end

    // Data captured at the address handshake, held while rvalid waits
    always_ff @(posedge i_clk) begin
        if (rd_fire) begin
            o_s_axi_rdata <= rd_mux;
        end
    end

endmodule

// File: pll_status_collect.sv
// Status packing and sticky done events; supports at most 8 channels in the 32-bit word
`timescale 1ns/1ps
module pll_status_collect (
    input  logic                              i_clk,
    input  logic                              i_arst_n,
    input  logic [pll_rst_pkg::PLL_NUM-1:0]   i_done,
    input  logic [pll_rst_pkg::PLL_NUM-1:0]   i_lock,
    input  logic [2*pll_rst_pkg::PLL_NUM-1:0] i_wd_cnt,
    input  logic [pll_rst_pkg::PLL_NUM-1:0]   i_evt_clr,
    output logic [31:0]                       o_status,
    output logic [31:0]                       o_event,
    output logic                              o_irq
);

    logic [pll_rst_pkg::PLL_NUM-1:0] done_q;
    logic [pll_rst_pkg::PLL_NUM-1:0] done_rise;
    logic [pll_rst_pkg::PLL_NUM-1:0] evt_q;

    assign done_rise = i_done & ~done_q;

    // Edge detect and sticky events, a new edge beats a clear
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            done_q <= '0;
            evt_q  <= '0;
        end else begin
            done_q <= i_done;
            evt_q  <= (evt_q & ~i_evt_clr) | done_rise;
        end
    end

    //////////////////////////////////////////////////
    // Register words
    //////////////////////////////////////////////////
    always_comb begin
        o_status = '0;
        o_status[pll_rst_pkg::PLL_NUM-1:0]  = i_done;
        o_status[8 +: pll_rst_pkg::PLL_NUM] = i_lock;
        // Two count bits per channel from bit 16
        o_status[16 +: 2*pll_rst_pkg::PLL_NUM] = i_wd_cnt;
        o_event = '0;
        o_event[pll_rst_pkg::PLL_NUM-1:0] = evt_q;
    end

    assign o_irq = |evt_q;

endmodule

// File: pll_rst_top.sv
// Top level of the PLL reset sequencer; channel count fixed by the package, one clock domain
`timescale 1ns/1ps
module pll_rst_top (
    input  logic                            i_clk,
    input  logic                            i_arst_n,
    input  logic [31:0]                     i_s_axi_awaddr,
    input  logic                            i_s_axi_awvalid,
    output logic                            o_s_axi_awready,
    input  logic [31:0]                     i_s_axi_wdata,
    input  logic                            i_s_axi_wvalid,
    output logic                            o_s_axi_wready,
    output logic [1:0]                      o_s_axi_bresp,
    output logic                            o_s_axi_bvalid,
    input  logic                            i_s_axi_bready,
    input  logic [31:0]                     i_s_axi_araddr,
    input  logic                            i_s_axi_arvalid,
    output logic                            o_s_axi_arready,
    output logic [31:0]                     o_s_axi_rdata,
    output logic [1:0]                      o_s_axi_rresp,
    output logic                            o_s_axi_rvalid,
    input  logic                            i_s_axi_rready,
    // PLL side, ready is asynchronous
    input  logic [pll_rst_pkg::PLL_NUM-1:0] i_pll_ready,
    output logic [pll_rst_pkg::PLL_NUM-1:0] o_pll_powerdown,
    output logic [pll_rst_pkg::PLL_NUM-1:0] o_pll_rst,
    output logic                            o_irq
);

    logic [pll_rst_pkg::PLL_NUM-1:0]   soft_rst;
    logic [pll_rst_pkg::PLL_NUM-1:0]   wd_clr;
    logic [pll_rst_pkg::PLL_NUM-1:0]   evt_clr;
    logic [pll_rst_pkg::PLL_NUM-1:0]   done;
    logic [pll_rst_pkg::PLL_NUM-1:0]   lock;
    logic [2*pll_rst_pkg::PLL_NUM-1:0] wd_cnt;
    logic [31:0]                       status;
    logic [31:0]                       event_word;

    pll_rst_csr u_csr (
        .i_clk           (i_clk),
        .i_arst_n        (i_arst_n),
        .i_s_axi_awaddr  (i_s_axi_awaddr),
        .i_s_axi_awvalid (i_s_axi_awvalid),
        .o_s_axi_awready (o_s_axi_awready),
        .i_s_axi_wdata   (i_s_axi_wdata),
        .i_s_axi_wvalid  (i_s_axi_wvalid),
        .o_s_axi_wready  (o_s_axi_wready),
        .o_s_axi_bresp   (o_s_axi_bresp),
        .o_s_axi_bvalid  (o_s_axi_bvalid),
        .i_s_axi_bready  (i_s_axi_bready),
        .i_s_axi_araddr  (i_s_axi_araddr),
        .i_s_axi_arvalid (i_s_axi_arvalid),
        .o_s_axi_arready (o_s_axi_arready),
        .o_s_axi_rdata   (o_s_axi_rdata),
        .o_s_axi_rresp   (o_s_axi_rresp),
        .o_s_axi_rvalid  (o_s_axi_rvalid),
        .i_s_axi_rready  (i_s_axi_rready),
        .i_status        (status),
        .i_event         (event_word),
        .o_soft_rst      (soft_rst),
        .o_wd_clr        (wd_clr),
        .o_evt_clr       (evt_clr)
    );

    // One identical channel per PLL
    for (genvar g = 0; g < pll_rst_pkg::PLL_NUM; g++) begin : g_chan
        pll_rst_chan u_chan (
            .i_clk           (i_clk),
            .i_arst_n        (i_arst_n),
            .i_soft_rst      (soft_rst[g]),
            .i_wd_clr        (wd_clr[g]),
            .i_pll_ready     (i_pll_ready[g]),
            .o_pll_powerdown (o_pll_powerdown[g]),
            .o_pll_rst       (o_pll_rst[g]),
            .o_done          (done[g]),
            .o_lock          (lock[g]),
            .o_wd_cnt        (wd_cnt[2*g +: 2])
        );
    end

    pll_status_collect u_collect (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_done    (done),
        .i_lock    (lock),
        .i_wd_cnt  (wd_cnt),
        .i_evt_clr (evt_clr),
        .o_status  (status),
        .o_event   (event_word),
        .o_irq     (o_irq)
    );

endmodule

// File: pll_rst_assert.sv
// Protocol and pin checks bound into the top level; bus rules are idle during reset
`timescale 1ns/1ps
module pll_rst_assert (
    input logic                            i_clk,
    input logic                            i_arst_n,
    input logic                            i_bvalid,
    input logic                            i_bready,
    input logic                            i_rvalid,
    input logic                            i_rready,
    input logic [31:0]                     i_rdata,
    input logic [pll_rst_pkg::PLL_NUM-1:0] i_pll_powerdown,
    input logic [pll_rst_pkg::PLL_NUM-1:0] i_pll_rst,
    input logic                            i_irq,
    input logic [31:0]                     i_event
);

    // Write response waits for bready
    a_bvalid_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_bvalid && !i_bready) |=> i_bvalid)
        else $error("bvalid dropped before bready");

    // Read data frozen while rvalid waits
    a_rvalid_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_rvalid && !i_rready) |=> (i_rvalid && $stable(i_rdata)))
        else $error("rvalid or rdata changed before rready");

    // No channel in power-down without reset
    a_pd_rst: assert property (@(posedge i_clk)
        (i_pll_powerdown & ~i_pll_rst) == '0)
        else $error("powerdown high while rst is low");

    a_irq: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_irq == (i_event != 32'h0))
        else $error("irq does not match the event register");

endmodule

bind pll_rst_top pll_rst_assert u_assert (
    .i_clk           (i_clk),
    .i_arst_n        (i_arst_n),
    .i_bvalid        (o_s_axi_bvalid),
    .i_bready        (i_s_axi_bready),
    .i_rvalid        (o_s_axi_rvalid),
    .i_rready        (i_s_axi_rready),
    .i_rdata         (o_s_axi_rdata),
    .i_pll_powerdown (o_pll_powerdown),
    .i_pll_rst       (o_pll_rst),
    .i_irq           (o_irq),
    .i_event         (event_word)
);

// File: pll_rst_tb.sv
// Trace-driven testbench; run from the project root to find the trace, stops at the first error
`timescale 1ns/1ps
module pll_rst_tb;

    logic                            clk;
    logic                            arst_n;
    logic [31:0]                     awaddr;
    logic                            awvalid;
    logic                            awready;
    logic [31:0]                     wdata;
    logic                            wvalid;
    logic                            wready;
    logic [1:0]                      bresp;
    logic                            bvalid;
    logic                            bready;
    logic [31:0]                     araddr;
    logic                            arvalid;
    logic                            arready;
    logic [31:0]                     rdata;
    logic [1:0]                      rresp;
    logic                            rvalid;
    logic                            rready;
    logic [pll_rst_pkg::PLL_NUM-1:0] pll_ready;
    logic [pll_rst_pkg::PLL_NUM-1:0] pll_powerdown;
    logic [pll_rst_pkg::PLL_NUM-1:0] pll_rst;
    logic                            irq;
    // End-of-run bookkeeping
    logic                            run_done = 1'b0;
    logic                            fail_shown = 1'b0;
    // Handshake budget in cycles
    int                              wait_limit = 32;

    pll_rst_top uut (
        .i_clk           (clk),
        .i_arst_n        (arst_n),
        .i_s_axi_awaddr  (awaddr),
        .i_s_axi_awvalid (awvalid),
        .o_s_axi_awready (awready),
        .i_s_axi_wdata   (wdata),
        .i_s_axi_wvalid  (wvalid),
        .o_s_axi_wready  (wready),
        .o_s_axi_bresp   (bresp),
        .o_s_axi_bvalid  (bvalid),
        .i_s_axi_bready  (bready),
        .i_s_axi_araddr  (araddr),
        .i_s_axi_arvalid (arvalid),
        .o_s_axi_arready (arready),
        .o_s_axi_rdata   (rdata),
        .o_s_axi_rresp   (rresp),
        .o_s_axi_rvalid  (rvalid),
        .i_s_axi_rready  (rready),
        .i_pll_ready     (pll_ready),
        .o_pll_powerdown (pll_powerdown),
        .o_pll_rst       (pll_rst),
        .o_irq           (irq)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Checking helpers
    //////////////////////////////////////////////////
    task automatic abort_run();
        fail_shown = 1'b1;
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // Compare under a mask, report the masked values
    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act, input logic [31:0] mask);
        assert (((exp ^ act) & mask) == 32'h0) else begin
            $display("error at %0t ns: %s expected %h, got %h",
                     $time, name, exp & mask, act & mask);
            abort_run();
        end
    endtask

    // PLL pins under a channel mask, irq always
    task automatic check_ports(input logic [31:0] pd, input logic [31:0] rst,
                               input logic [31:0] irq_exp, input logic [31:0] mask);
        check_val("o_pll_powerdown", pd, 32'(pll_powerdown), mask);
        check_val("o_pll_rst", rst, 32'(pll_rst), mask);
        check_val("o_irq", irq_exp, 32'(irq), 32'h1);
    endtask

    // Trace line must carry all fields of its command
    task automatic check_field_count(input int got, input int want, input string line);
        assert (got == want) else begin
            $display("malformed trace line, %0d fields found where %0d are needed: %s",
                     got, want, line);
            abort_run();
        end
    endtask

    //////////////////////////////////////////////////
    // AXI4-Lite master tasks, entered on a falling edge
    //////////////////////////////////////////////////
    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data);
        int t;
        t       = 0;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        // Both ready lines answer together while no response is pending
        #1;
        check_val("o_s_axi_awready", 32'h1, 32'(awready), 32'h1);
        check_val("o_s_axi_wready", 32'h1, 32'(wready), 32'h1);
        @(negedge clk);
        // bvalid only follows the address and data handshake
        while (!bvalid) begin
            t++;
            if (t > wait_limit) begin
                $display("timeout waiting for the write response to offset %h at %0t ns",
                         addr, $time);
                abort_run();
            end
            @(negedge clk);
        end
        // Still offered, the pending response blocks a second accept
        check_val("o_s_axi_awready", 32'h0, 32'(awready), 32'h1);
        check_val("o_s_axi_wready", 32'h0, 32'(wready), 32'h1);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        check_val("o_s_axi_bresp", 32'h0, 32'(bresp), 32'h3);
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr, input int hold,
                            output logic [31:0] data);
        int t;
        t       = 0;
        araddr  = addr;
        arvalid = 1'b1;
        // Held read keeps rready low for a while
        rready  = (hold == 0);
        @(negedge clk);
        while (!rvalid) begin
            t++;
            if (t > wait_limit) begin
                $display("timeout waiting for read data from offset %h at %0t ns",
                         addr, $time);
                abort_run();
            end
            @(negedge clk);
        end
        data = rdata;
        check_val("o_s_axi_rresp", 32'h0, 32'(rresp), 32'h3);
        // Next read offered while the response is pending
        araddr  = pll_rst_pkg::REG_CTRL;
        arvalid = (hold > 0);
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check_val("o_s_axi_rvalid", 32'h1, 32'(rvalid), 32'h1);
            check_val("o_s_axi_rdata", data, rdata, 32'hffff_ffff);
            check_val("o_s_axi_arready", 32'h0, 32'(arready), 32'h1);
        end
        arvalid = 1'b0;
        rready  = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Trace player
    //////////////////////////////////////////////////
    task automatic run_trace();
        int          fd;
        int          n_f;
        int          r;
        string       line;
        logic [7:0]  cmd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] got;
        fd = $fopen("pll_rst_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file pll_rst_trace.txt");
            abort_run();
        end
        r = $fgets(line, fd);
        while (r > 0) begin
            n_f = $sscanf(line, "%s", cmd);
            if (n_f < 1) begin
                // Blank line
                cmd = 8'h0;
            end
            case (cmd)
                8'h0, "#": begin
                    // Blank line or comment
                end
                "s": begin
                    n_f = $sscanf(line, "%s %h", cmd, a);
                    check_field_count(n_f, 2, line);
                    pll_ready = a[pll_rst_pkg::PLL_NUM-1:0];
                end
                "d": begin
                    n_f = $sscanf(line, "%s %d", cmd, a);
                    check_field_count(n_f, 2, line);
                    repeat (a) @(negedge clk);
                end
                "w": begin
                    n_f = $sscanf(line, "%s %h %h", cmd, a, b);
                    check_field_count(n_f, 3, line);
                    axi_write(a, b);
                end
                "r": begin
                    n_f = $sscanf(line, "%s %h %h %h", cmd, a, b, c);
                    check_field_count(n_f, 4, line);
                    axi_read(a, 0, got);
                    check_val($sformatf("o_s_axi_rdata at offset %h", a), b, got, c);
                end
                "h": begin
                    n_f = $sscanf(line, "%s %h %h %h %d", cmd, a, b, c, d);
                    check_field_count(n_f, 5, line);
                    axi_read(a, int'(d), got);
                    check_val($sformatf("o_s_axi_rdata at offset %h", a), b, got, c);
                end
                "p": begin
                    n_f = $sscanf(line, "%s %h %h %h %h", cmd, a, b, c, d);
                    check_field_count(n_f, 5, line);
                    check_ports(a, b, c, d);
                end
                default: begin
                    $display("unknown trace command %s", cmd);
                    abort_run();
                end
            endcase
            r = $fgets(line, fd);
        end
        $fclose(fd);
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        arst_n    = 1'b0;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        pll_ready = '0;
        repeat (5) @(negedge clk);
        // Reset levels on the pins and the bus
        check_ports(32'h3, 32'h3, 32'h0, 32'h3);
        check_val("o_s_axi_bvalid", 32'h0, 32'(bvalid), 32'h1);
        check_val("o_s_axi_rvalid", 32'h0, 32'(rvalid), 32'h1);
        check_val("o_s_axi_awready", 32'h0, 32'(awready), 32'h1);
        check_val("o_s_axi_wready", 32'h0, 32'(wready), 32'h1);
        check_val("o_s_axi_arready", 32'h0, 32'(arready), 32'h1);
        arst_n = 1'b1;
        run_trace();
        run_done = 1'b1;
        $display("All tests passed");
        $finish;
    end

    // Reached when a bound assertion ends the run early
    final begin
        if (!run_done && !fail_shown) begin
            $display("Some tests failed");
        end
    end

endmodule

// File: pll_rst_trace.txt
# s ready_mask | d cycles(dec) | w addr data | r addr expect mask | h addr expect mask hold(dec)
# p powerdown rst irq pll_mask, all other numbers hex
d 80
p 0 0 0 3
r 4 00000000 ffffffff
r 8 00000000 ffffffff
# PLL 0 locks, event and irq, then clear
s 1
d 100
r 4 00000101 ffffffff
r 8 00000001 ffffffff
p 0 0 1 1
w 8 00000001
r 8 00000000 ffffffff
p 0 0 0 1
# Soft reset of PLL 0
w 0 00000001
d 6
p 1 1 0 1
r 4 00000100 00000101
r 0 00000001 ffffffff
w 0 00000000
d 90
r 4 00000101 00000101
r 8 00000001 ffffffff
w 8 00000001
# Watchdog restarts on PLL 1, saturation, clear
d 1200
r 4 00040000 000f0000
d 2000
r 4 000c0000 000f0000
s 3
d 200
w 0 00000200
r 4 00000303 000f0303
r 0 00000000 ffffffff
w 8 00000003
# Lock loss on PLL 0
s 2
d 6
p 0 1 0 1
r 4 00000000 00000101
s 3
d 100
r 4 00000303 00000303
# Unused offset and held rready
r c 00000000 ffffffff
h 4 00000303 00000303 5
r 8 00000001 ffffffff

// File: all.f
pll_rst_pkg.sv
pll_rst_seq.sv
pll_rst_chan.sv
pll_rst_csr.sv
pll_status_collect.sv
pll_rst_top.sv
pll_rst_assert.sv
pll_rst_tb.sv

// File: Makefile
# Verilator flow for the PLL reset sequencer testbench
TOP := pll_rst_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f all.f --top $(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert -f all.f --top $(TOP)

clean:
	rm -rf obj_dir
